/* test/mem_noc_golden.txt */
// opcode(0 read, 1 write) address command_data expected_response_data
// With 16 words, addresses alias on their low 4 bits
0 00 00000000 00000000
0 07 00000000 00000000
0 3f 00000000 00000000
1 05 deadbeef deadbeef
0 05 00000000 deadbeef
1 13 cafe0013 cafe0013
0 03 00000000 cafe0013
0 a3 00000000 cafe0013
1 f3 12345678 12345678
0 33 00000000 12345678
1 08 11111111 11111111
1 09 22222222 22222222
1 0a 33333333 33333333
1 0b 44444444 44444444
0 08 00000000 11111111
0 09 00000000 22222222
0 0a 00000000 33333333
0 0b 00000000 44444444
0 0c 00000000 00000000
1 ff a5a5a5a5 a5a5a5a5
0 0f 00000000 a5a5a5a5
0 05 00000000 deadbeef

/* sources.f */
rtl/mem_noc_pkg.sv
rtl/mem_cmd_pkg.sv
rtl/cmd_packet_encode.sv
rtl/wormhole_link_adapter.sv
rtl/cce_to_wormhole_link_master.sv
rtl/mem_execute.sv
rtl/wormhole_link_client.sv
rtl/mem_noc_top.sv
test/mem_noc_sva.sv
test/tb_mem_noc_top.sv

/* Bender.yml */
package:
  name: mem_noc

sources:
  - rtl/mem_noc_pkg.sv
  - rtl/mem_cmd_pkg.sv
  - rtl/cmd_packet_encode.sv
  - rtl/wormhole_link_adapter.sv
  - rtl/cce_to_wormhole_link_master.sv
  - rtl/mem_execute.sv
  - rtl/wormhole_link_client.sv
  - rtl/mem_noc_top.sv
  - target: test
    files:
      - test/mem_noc_sva.sv
      - test/tb_mem_noc_top.sv

/* test/tb_mem_noc_top.sv */
// ----------------------------------------------------------------------
// Testbench for mem_noc_top, driven from test/mem_noc_golden.txt.
// Golden columns: opcode, address, command data, expected response data.
// Response ready is random back-pressure; the run stops at the first error.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mem_noc_top;

  import mem_noc_pkg::*;
  import mem_cmd_pkg::*;

  localparam noc_cord_t master_cord     = 4'd1;
  localparam noc_cord_t client_cord     = 4'd6;
  localparam int        mem_words       = 16;
  localparam int        clk_half_ns     = 5;
  localparam int        drive_skew_ns   = 1;
  localparam int        max_lines       = 64;
  localparam int        cycles_per_line = 100;
  localparam int        drain_cycles    = 20;

  logic     clk_i;
  logic     rst_n_i;
  mem_msg_t mem_cmd_i;
  logic     mem_cmd_v_i;
  logic     mem_cmd_yumi_o;
  mem_msg_t mem_resp_o;
  logic     mem_resp_v_o;
  logic     mem_resp_ready_i;

  logic [31:0] golden_mem [0:max_lines*4-1];
  mem_msg_t    cmd_queue[$];
  mem_msg_t    pending_exp[$];
  mem_msg_t    exp_queue[$];
  int          line_count;
  int          resp_count;
  int          error_count;
  logic [31:0] lfsr_q;
  logic        loaded;

  mem_noc_top #(
    .master_cord_p (master_cord),
    .client_cord_p (client_cord),
    .mem_words_p   (mem_words)
  ) u_dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mem_cmd_i        (mem_cmd_i),
    .mem_cmd_v_i      (mem_cmd_v_i),
    .mem_cmd_yumi_o   (mem_cmd_yumi_o),
    .mem_resp_o       (mem_resp_o),
    .mem_resp_v_o     (mem_resp_v_o),
    .mem_resp_ready_i (mem_resp_ready_i)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic stop_on_error(input string what);
    error_count++;
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic compare_msg(input mem_msg_t got, input mem_msg_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                              $time, what, got, exp));
    end
  endtask

  task automatic compare_data(input mem_data_t got, input mem_data_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                              $time, what, got, exp));
    end
  endtask

  task automatic load_golden;
    logic      op;
    mem_addr_t addr;
    for (int i = 0; i < max_lines * 4; i++) begin
      golden_mem[i] = {16'hdead, 16'(i)};
    end
    $readmemh("test/mem_noc_golden.txt", golden_mem);
    line_count = 0;
    // List ends at the first opcode column that is not 0 or 1
    while (line_count < max_lines && golden_mem[4*line_count] <= 32'd1) begin
      op   = golden_mem[4*line_count][0];
      addr = golden_mem[4*line_count+1][7:0];
      cmd_queue.push_back({op, addr, golden_mem[4*line_count+2]});
      pending_exp.push_back({op, addr, golden_mem[4*line_count+3]});
      line_count++;
    end
    if (line_count == 0) begin
      stop_on_error("Golden file is missing or holds no commands");
    end
  endtask

  task automatic check_response;
    mem_msg_t exp;
    if (exp_queue.size() == 0) begin
      stop_on_error("Response arrived with no command outstanding");
    end else begin
      exp = exp_queue.pop_front();
      compare_data(mem_resp_o[31:0], exp[31:0], $sformatf("response %0d data", resp_count));
      compare_msg(mem_resp_o, exp, $sformatf("response %0d message", resp_count));
      resp_count++;
    end
  endtask

  function automatic int unsigned assertion_failures;
    return u_dut.u_master.u_adapter.u_sva.fail_count +
           u_dut.u_client.u_adapter.u_sva.fail_count;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #clk_half_ns clk_i = ~clk_i;
  end

  // One LFSR bit per cycle for response ready
  initial begin
    lfsr_q = 32'h2e74_c563;
    forever begin
      @(posedge clk_i);
      #drive_skew_ns;
      lfsr_q           = lfsr_step(lfsr_q);
      mem_resp_ready_i = lfsr_q[0];
    end
  end

  // Handshake completes on the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && mem_resp_v_o === 1'b1 && mem_resp_ready_i === 1'b1) begin
      check_response();
    end
    if (loaded && assertion_failures() != 0) begin
      stop_on_error("A link adapter assertion failed");
    end
  end

  initial begin
    wait (loaded);
    #((line_count * cycles_per_line) * 2 * clk_half_ns);
    stop_on_error($sformatf("Timeout with %0d of %0d responses received",
                            resp_count, line_count));
  end

  initial begin
    logic taken;
    rst_n_i          = 1'b0;
    mem_cmd_i        = '0;
    mem_cmd_v_i      = 1'b0;
    mem_resp_ready_i = 1'b0;
    resp_count       = 0;
    error_count      = 0;
    loaded           = 1'b0;
    load_golden();
    loaded = 1'b1;

    repeat (2) @(posedge clk_i);
    #drive_skew_ns;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #drive_skew_ns;

    while (cmd_queue.size() > 0) begin
      mem_cmd_i   = cmd_queue.pop_front();
      mem_cmd_v_i = 1'b1;
      taken       = 1'b0;
      while (!taken) begin
        @(negedge clk_i);
        taken = mem_cmd_yumi_o;
        if (taken) begin
          exp_queue.push_back(pending_exp.pop_front());
        end
        @(posedge clk_i);
        #drive_skew_ns;
      end
    end
    mem_cmd_v_i = 1'b0;

    while (exp_queue.size() != 0) begin
      @(posedge clk_i);
    end
    // Idle cycles catch a duplicated response
    repeat (drain_cycles) @(posedge clk_i);

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* test/mem_noc_sva.sv */
// ----------------------------------------------------------------------
// Handshake assertions for every link adapter instance.
// Failures go through $error and are counted in fail_count.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_noc_sva (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input mem_noc_pkg::noc_flit_t   link_data_o,
  input logic                     link_v_o,
  input logic                     link_ready_and_i,
  input mem_noc_pkg::noc_packet_t packet_o,
  input logic                     v_o,
  input logic                     yumi_i
);

  int unsigned fail_count = 0;

  // Outgoing flit holds until the link takes it
  link_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      link_v_o && !link_ready_and_i |=> link_v_o && $stable(link_data_o))
    else begin
      fail_count++;
      $error("Link valid dropped or flit changed before ready");
    end

  packet_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      v_o && !yumi_i |=> v_o && $stable(packet_o))
    else begin
      fail_count++;
      $error("Received packet dropped or changed before yumi");
    end

  link_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !link_v_o)
    else begin
      fail_count++;
      $error("Link valid high while in reset");
    end

endmodule

bind wormhole_link_adapter mem_noc_sva u_sva (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .link_data_o      (link_data_o),
  .link_v_o         (link_v_o),
  .link_ready_and_i (link_ready_and_i),
  .packet_o         (packet_o),
  .v_o              (v_o),
  .yumi_i           (yumi_i)
);

/* rtl/mem_noc_top.sv */
// ----------------------------------------------------------------------
// Master and memory node wired back to back, no router in between.
// Coordinates must differ; mem_words_p is a power of two.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_noc_top #(
  parameter mem_noc_pkg::noc_cord_t master_cord_p = 4'd1,
  parameter mem_noc_pkg::noc_cord_t client_cord_p = 4'd2,
  parameter int                     mem_words_p   = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_cmd_pkg::mem_msg_t mem_cmd_i,
  input  logic                  mem_cmd_v_i,
  output logic                  mem_cmd_yumi_o,
  output mem_cmd_pkg::mem_msg_t mem_resp_o,
  output logic                  mem_resp_v_o,
  input  logic                  mem_resp_ready_i
);

  import mem_noc_pkg::*;

  // Master to client link
  noc_flit_t m2c_data;
  logic      m2c_v;
  logic      m2c_ready;
  // Client to master link
  noc_flit_t c2m_data;
  logic      c2m_v;
  logic      c2m_ready;

  cce_to_wormhole_link_master #(
    .master_cord_p (master_cord_p),
    .client_cord_p (client_cord_p)
  ) u_master (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mem_cmd_i        (mem_cmd_i),
    .mem_cmd_v_i      (mem_cmd_v_i),
    .mem_cmd_yumi_o   (mem_cmd_yumi_o),
    .mem_resp_o       (mem_resp_o),
    .mem_resp_v_o     (mem_resp_v_o),
    .mem_resp_ready_i (mem_resp_ready_i),
    .link_data_i      (c2m_data),
    .link_v_i         (c2m_v),
    .link_ready_and_o (c2m_ready),
    .link_data_o      (m2c_data),
    .link_v_o         (m2c_v),
    .link_ready_and_i (m2c_ready)
  );

  wormhole_link_client #(
    .client_cord_p (client_cord_p),
    .mem_words_p   (mem_words_p)
  ) u_client (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .link_data_i      (m2c_data),
    .link_v_i         (m2c_v),
    .link_ready_and_o (m2c_ready),
    .link_data_o      (c2m_data),
    .link_v_o         (c2m_v),
    .link_ready_and_i (c2m_ready)
  );

endmodule

/* rtl/wormhole_link_client.sv */
// ----------------------------------------------------------------------
// Memory node on the link. Answers every command to its source.
// Only one command is held between receive and response.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module wormhole_link_client #(
  parameter mem_noc_pkg::noc_cord_t client_cord_p = 4'd2,
  parameter int                     mem_words_p   = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_noc_pkg::noc_flit_t link_data_i,
  input  logic                   link_v_i,
  output logic                   link_ready_and_o,
  output mem_noc_pkg::noc_flit_t link_data_o,
  output logic                   link_v_o,
  input  logic                   link_ready_and_i
);

  import mem_noc_pkg::*;
  import mem_cmd_pkg::*;

  noc_packet_t recv_packet;
  logic        recv_v;
  noc_packet_t send_packet;
  logic        send_ready;

  mem_msg_t    cmd_msg;
  logic        cmd_ready;
  mem_msg_t    resp_msg;
  logic        resp_v;
  noc_cord_t   src_q;

  assign cmd_msg = recv_packet[noc_msg_lsb +: noc_msg_width];

  // Return address for the response in progress
  always_ff @(posedge clk_i) begin
    if (recv_v && cmd_ready) begin
      src_q <= recv_packet[noc_src_lsb +: noc_cord_width];
    end
  end

  always_comb begin
    send_packet = '0;
    send_packet[noc_dst_lsb +: noc_cord_width] = src_q;
    send_packet[noc_len_lsb +: noc_len_width]  = noc_len_t'(noc_flits_per_packet - 1);
    send_packet[noc_src_lsb +: noc_cord_width] = client_cord_p;
    send_packet[noc_msg_lsb +: noc_msg_width]  = resp_msg;
  end

  wormhole_link_adapter u_adapter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .packet_i         (send_packet),
    .v_i              (resp_v),
    .ready_o          (send_ready),
    .link_data_i      (link_data_i),
    .link_v_i         (link_v_i),
    .link_ready_and_o (link_ready_and_o),
    .link_data_o      (link_data_o),
    .link_v_o         (link_v_o),
    .link_ready_and_i (link_ready_and_i),
    .packet_o         (recv_packet),
    .v_o              (recv_v),
    .yumi_i           (recv_v & cmd_ready)
  );

  mem_execute #(
    .mem_words_p (mem_words_p)
  ) u_execute (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (cmd_msg),
    .cmd_v_i     (recv_v),
    .cmd_ready_o (cmd_ready),
    .resp_o      (resp_msg),
    .resp_v_o    (resp_v),
    .resp_yumi_i (resp_v & send_ready)
  );

endmodule

/* rtl/mem_execute.sv */
// ----------------------------------------------------------------------
// Small word memory, one command at a time.
// mem_words_p must be a power of two, at least 2; upper address
// bits alias onto the same words.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_execute #(
  parameter int mem_words_p = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_cmd_pkg::mem_msg_t cmd_i,
  input  logic                  cmd_v_i,
  output logic                  cmd_ready_o,
  output mem_cmd_pkg::mem_msg_t resp_o,
  output logic                  resp_v_o,
  input  logic                  resp_yumi_i
);

  import mem_cmd_pkg::*;

  localparam int idx_width = $clog2(mem_words_p);

  mem_op_e               cmd_op;
  mem_addr_t             cmd_addr;
  mem_data_t             cmd_data;
  logic [idx_width-1:0]  cmd_idx;
  mem_data_t             rd_data;
  logic                  cmd_take;

  mem_data_t mem_q [mem_words_p];
  mem_msg_t  resp_q;
  logic      resp_v_q;

  assign cmd_op   = mem_op_e'(cmd_i[mem_msg_op_bit]);
  assign cmd_addr = cmd_i[mem_msg_addr_lsb +: $bits(mem_addr_t)];
  assign cmd_data = cmd_i[$bits(mem_data_t)-1:0];
  assign cmd_idx  = cmd_addr[idx_width-1:0];
  assign rd_data  = mem_q[cmd_idx];

  // Blocked until the pending response is taken
  assign cmd_ready_o = ~resp_v_q;
  assign cmd_take    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < mem_words_p; i++) begin
        mem_q[i] <= '0;
      end
      resp_v_q <= 1'b0;
    end else begin
      if (cmd_take && (cmd_op == mem_write)) begin
        mem_q[cmd_idx] <= cmd_data;
      end
      if (cmd_take) begin
        resp_v_q <= 1'b1;
      end else if (resp_yumi_i) begin
        resp_v_q <= 1'b0;
      end
    end
  end

  // Writes echo their own data, reads return the old word
  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      resp_q <= {cmd_op, cmd_addr, (cmd_op == mem_write) ? cmd_data : rd_data};
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

/* rtl/cce_to_wormhole_link_master.sv */
// ----------------------------------------------------------------------
// Controller side of the memory link.
// Commands use valid-yumi, responses ready-valid.
// All commands go to client_cord_p.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cce_to_wormhole_link_master #(
  parameter mem_noc_pkg::noc_cord_t master_cord_p = 4'd1,
  parameter mem_noc_pkg::noc_cord_t client_cord_p = 4'd2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_cmd_pkg::mem_msg_t  mem_cmd_i,
  input  logic                   mem_cmd_v_i,
  output logic                   mem_cmd_yumi_o,
  output mem_cmd_pkg::mem_msg_t  mem_resp_o,
  output logic                   mem_resp_v_o,
  input  logic                   mem_resp_ready_i,
  input  mem_noc_pkg::noc_flit_t link_data_i,
  input  logic                   link_v_i,
  output logic                   link_ready_and_o,
  output mem_noc_pkg::noc_flit_t link_data_o,
  output logic                   link_v_o,
  input  logic                   link_ready_and_i
);

  import mem_noc_pkg::*;

  noc_packet_t send_packet;
  logic        send_ready;
  noc_packet_t recv_packet;
  logic        recv_v;

  cmd_packet_encode u_cmd_encode (
    .mem_cmd_i  (mem_cmd_i),
    .src_cord_i (master_cord_p),
    .dst_cord_i (client_cord_p),
    .packet_o   (send_packet)
  );

  // Command is taken as soon as the send buffer is free
  assign mem_cmd_yumi_o = mem_cmd_v_i & send_ready;

  wormhole_link_adapter u_adapter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .packet_i         (send_packet),
    .v_i              (mem_cmd_v_i),
    .ready_o          (send_ready),
    .link_data_i      (link_data_i),
    .link_v_i         (link_v_i),
    .link_ready_and_o (link_ready_and_o),
    .link_data_o      (link_data_o),
    .link_v_o         (link_v_o),
    .link_ready_and_i (link_ready_and_i),
    .packet_o         (recv_packet),
    .v_o              (recv_v),
    .yumi_i           (recv_v & mem_resp_ready_i)
  );

  assign mem_resp_o   = recv_packet[noc_msg_lsb +: noc_msg_width];
  assign mem_resp_v_o = recv_v;

endmodule

/* rtl/wormhole_link_adapter.sv */
// ----------------------------------------------------------------------
// Packet to flit serializer and flit to packet reassembler.
// Receive side assumes full-size packets, since the shift register
// only lines up when all four flits arrive.
// One packet buffered per direction.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module wormhole_link_adapter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Packet in, to be sent on the link
  input  mem_noc_pkg::noc_packet_t packet_i,
  input  logic                     v_i,
  output logic                     ready_o,
  // Incoming link
  input  mem_noc_pkg::noc_flit_t   link_data_i,
  input  logic                     link_v_i,
  output logic                     link_ready_and_o,
  // Outgoing link
  output mem_noc_pkg::noc_flit_t   link_data_o,
  output logic                     link_v_o,
  input  logic                     link_ready_and_i,
  // Reassembled packet out
  output mem_noc_pkg::noc_packet_t packet_o,
  output logic                     v_o,
  input  logic                     yumi_i
);

  import mem_noc_pkg::*;

  typedef enum logic {
    send_idle,
    send_busy
  } send_state_e;

  typedef enum logic {
    recv_fill,
    recv_full
  } recv_state_e;

  send_state_e send_state_q;
  noc_len_t    send_left_q;
  noc_packet_t send_q;

  recv_state_e recv_state_q;
  logic        recv_head_q;
  noc_len_t    recv_left_q;
  noc_packet_t recv_q;
  noc_len_t    head_len;

  // Send side
  assign ready_o     = (send_state_q == send_idle);
  assign link_v_o    = (send_state_q == send_busy);
  assign link_data_o = send_q[noc_flit_width-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      send_state_q <= send_idle;
      send_left_q  <= '0;
    end else begin
      case (send_state_q)
        send_idle: begin
          if (v_i) begin
            send_state_q <= send_busy;
            send_left_q  <= packet_i[noc_len_lsb +: noc_len_width];
          end
        end
        send_busy: begin
          if (link_ready_and_i) begin
            // Last flit leaves when no flits are left behind it
            if (send_left_q == '0) begin
              send_state_q <= send_idle;
            end else begin
              send_left_q <= send_left_q - 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      send_q <= packet_i;
    end else if (link_v_o && link_ready_and_i) begin
      send_q <= send_q >> noc_flit_width;
    end
  end

  // Receive side
  assign head_len         = link_data_i[noc_len_lsb +: noc_len_width];
  assign link_ready_and_o = (recv_state_q == recv_fill);
  assign v_o              = (recv_state_q == recv_full);
  assign packet_o         = recv_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      recv_state_q <= recv_fill;
      recv_head_q  <= 1'b1;
      recv_left_q  <= '0;
    end else begin
      case (recv_state_q)
        recv_fill: begin
          if (link_v_i) begin
            if (recv_head_q) begin
              recv_left_q <= head_len;
              recv_head_q <= (head_len == '0);
              if (head_len == '0) begin
                recv_state_q <= recv_full;
              end
            end else begin
              recv_left_q <= recv_left_q - 1'b1;
              if (recv_left_q == noc_len_t'(1)) begin
                recv_state_q <= recv_full;
                recv_head_q  <= 1'b1;
              end
            end
          end
        end
        recv_full: begin
          if (yumi_i) begin
            recv_state_q <= recv_fill;
          end
        end
      endcase
    end
  end

  // Flits enter at the top, so the head ends up in the low bits
  always_ff @(posedge clk_i) begin
    if (link_v_i && link_ready_and_o) begin
      recv_q <= {link_data_i, recv_q[noc_packet_width-1:noc_flit_width]};
    end
  end

endmodule

/* rtl/cmd_packet_encode.sv */
// ----------------------------------------------------------------------
// Combinational framing of a memory command into a wormhole packet.
// Length is fixed to a full four-flit packet; upper bits are zero.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cmd_packet_encode (
  input  mem_cmd_pkg::mem_msg_t    mem_cmd_i,
  input  mem_noc_pkg::noc_cord_t   src_cord_i,
  input  mem_noc_pkg::noc_cord_t   dst_cord_i,
  output mem_noc_pkg::noc_packet_t packet_o
);

  import mem_noc_pkg::*;

  // Length field counts flits after the head
  localparam noc_len_t pkt_len = noc_len_t'(noc_flits_per_packet - 1);

  always_comb begin
    packet_o = '0;
    packet_o[noc_dst_lsb +: noc_cord_width] = dst_cord_i;
    packet_o[noc_len_lsb +: noc_len_width]  = pkt_len;
    packet_o[noc_src_lsb +: noc_cord_width] = src_cord_i;
    packet_o[noc_msg_lsb +: noc_msg_width]  = mem_cmd_i;
  end

endmodule

/* rtl/mem_cmd_pkg.sv */
// ----------------------------------------------------------------------
// Memory command and response message, one 32-bit word per message.
// Commands and responses share one layout: data low, then address,
// opcode in the top bit.
// ----------------------------------------------------------------------
package mem_cmd_pkg;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  typedef logic [7:0]  mem_addr_t;
  typedef logic [31:0] mem_data_t;

  localparam int mem_msg_addr_lsb = $bits(mem_data_t);
  localparam int mem_msg_op_bit   = mem_msg_addr_lsb + $bits(mem_addr_t);
  localparam int mem_msg_width    = mem_msg_op_bit + 1;

  typedef logic [mem_msg_width-1:0] mem_msg_t;

endpackage

/* rtl/mem_noc_pkg.sv */
// ----------------------------------------------------------------------
// Link and packet framing for the memory network.
// Packets are always four 16-bit flits and the head flit goes first.
// Field order from bit 0 up: destination, length, source, message.
// ----------------------------------------------------------------------
package mem_noc_pkg;

  localparam int noc_cord_width       = 4;
  localparam int noc_len_width        = 3;
  localparam int noc_flit_width       = 16;
  localparam int noc_flits_per_packet = 4;
  localparam int noc_packet_width     = noc_flit_width * noc_flits_per_packet;

  // Bit offsets inside a packet
  localparam int noc_dst_lsb   = 0;
  localparam int noc_len_lsb   = noc_dst_lsb + noc_cord_width;
  localparam int noc_src_lsb   = noc_len_lsb + noc_len_width;
  localparam int noc_msg_lsb   = noc_src_lsb + noc_cord_width;
  localparam int noc_msg_width = 41;

  typedef logic [noc_cord_width-1:0]   noc_cord_t;
  typedef logic [noc_len_width-1:0]    noc_len_t;
  typedef logic [noc_flit_width-1:0]   noc_flit_t;
  typedef logic [noc_packet_width-1:0] noc_packet_t;

endpackage
